//--- common/rename_defines.svh
/* register counts are tied to the map-table width.
   PHYS_REGS must be a power of two, as the free list pointers wrap on it. */
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// architectural and physical register files.
`define ARCH_REGS 32
`define PHYS_REGS 64

// index widths.
`define AREG_W 5
`define PREG_W 6

// free list occupancy, 0 to PHYS_REGS.
`define FREE_CNT_W 7

// address and immediate width.
`define XLEN 32

`endif

//--- common/instr_pkg.sv
/* instruction-side types as decode hands them over.
   UNKNOWN marks an empty slot. */
`include "rename_defines.svh"

package instr_pkg;

    typedef logic [`AREG_W-1:0] areg_t;

    typedef enum logic [5:0] {
        UNKNOWN,
        LUI, AUIPC,
        JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        ADDI, SLTI, SLTIU, XORI, ORI, ANDI,
        SLLI, SRLI, SRAI,
        ADD, SUB, SLL, SLT, SLTU,
        XOR, SRL, SRA, OR, AND
    } instr_name_e;

    // tag is set when the instruction sits behind an unresolved jump.
    typedef struct packed {
        logic writes;
        logic jumps;
        logic tag;
    } instr_flags_t;

    typedef enum logic [1:0] {
        ST_NONE,
        ST_BYTE,
        ST_HALF,
        ST_WORD
    } st_type_e;

endpackage

//--- common/rename_pkg.sv
/* rename-side types.
   ERROR in the jump pattern only shows up on undefined flag bits. */
`include "rename_defines.svh"

package rename_pkg;

    typedef logic [`PREG_W-1:0] preg_t;

    // jump pattern of a pair, slot 0 first.
    typedef enum logic [2:0] {
        NJ1NJ2,
        NJ1J2,
        J1NJ2,
        J1J2,
        ERROR
    } instr_types_e;

endpackage

//--- hw/rename_table/free_list.sv
/* circular FIFO of free physical registers, no overflow or underflow check.
   the caller never pops more than count nor releases a register twice. */
`include "rename_defines.svh"

module free_list import rename_pkg::*; (
    input  logic                   global_bus,
    input  logic                   reset,
    input  logic [1:0]             alloc_count,
    input  logic                   alloc,
    output preg_t                  alloc_reg_0,
    output preg_t                  alloc_reg_1,
    output logic [`FREE_CNT_W-1:0] count,
    input  logic                   free_valid,
    input  preg_t                  free_reg
);

    preg_t fifo [`PHYS_REGS];

    logic [`PREG_W-1:0]     head;
    logic [`PREG_W-1:0]     tail;
    logic [`FREE_CNT_W-1:0] pop_n;

    // two oldest entries.
    assign alloc_reg_0 = fifo[head];
    assign alloc_reg_1 = fifo[head + 1'b1];

    assign pop_n = alloc ? `FREE_CNT_W'(alloc_count) : '0;

    always_ff @(posedge global_bus) begin
        if (reset) begin
            // registers above the architectural ones start out free.
            for (int i = 0; i < `PHYS_REGS - `ARCH_REGS; i++) begin
                fifo[i] <= preg_t'(`ARCH_REGS + i);
            end
            head  <= '0;
            tail  <= `PREG_W'(`PHYS_REGS - `ARCH_REGS);
            count <= `FREE_CNT_W'(`PHYS_REGS - `ARCH_REGS);
        end else begin
            if (free_valid) begin
                fifo[tail] <= free_reg;
                tail       <= tail + 1'b1;
            end
            if (alloc) begin
                head <= head + `PREG_W'(alloc_count);
            end
            count <= count + `FREE_CNT_W'(free_valid) - pop_n;
        end
    end

endmodule

//--- hw/rename_table/rename_table.sv
/* lookup is combinational; allocations and map writes happen on commit.
   slot 1 sources read the old map, in-pair bypass is left to the resolver. */
`include "rename_defines.svh"

module rename_table import rename_pkg::*; (
    input  logic              global_bus,
    input  logic              reset,
    input  logic [`AREG_W-1:0] rs_1_0,
    input  logic [`AREG_W-1:0] rs_2_0,
    input  logic [`AREG_W-1:0] rd_0,
    input  logic              rename_0,
    output preg_t             src_1_0,
    output preg_t             src_2_0,
    output preg_t             rn_0,
    input  logic [`AREG_W-1:0] rs_1_1,
    input  logic [`AREG_W-1:0] rs_2_1,
    input  logic [`AREG_W-1:0] rd_1,
    input  logic              rename_1,
    output preg_t             src_1_1,
    output preg_t             src_2_1,
    output preg_t             rn_1,
    input  logic              commit,
    output logic              no_free,
    input  logic              free_valid,
    input  preg_t             free_reg
);

    preg_t map [`ARCH_REGS];

    logic                   req_0;
    logic                   req_1;
    logic [1:0]             req_count;
    logic [`FREE_CNT_W-1:0] free_count;
    preg_t                  head_0;
    preg_t                  head_1;

    // x0 never gets a physical register.
    assign req_0     = rename_0 && rd_0 != '0;
    assign req_1     = rename_1 && rd_1 != '0;
    assign req_count = {1'b0, req_0} + {1'b0, req_1};
    assign no_free   = free_count < {{(`FREE_CNT_W-2){1'b0}}, req_count};

    assign src_1_0 = map[rs_1_0];
    assign src_2_0 = map[rs_2_0];
    assign src_1_1 = map[rs_1_1];
    assign src_2_1 = map[rs_2_1];

    // slot 1 takes the next entry only if slot 0 took one.
    assign rn_0 = head_0;
    assign rn_1 = req_0 ? head_1 : head_0;

    always_ff @(posedge global_bus) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map[i] <= preg_t'(i);
            end
        end else if (commit) begin
            // slot order, so slot 1 wins on the same rd.
            if (req_0) begin
                map[rd_0] <= rn_0;
            end
            if (req_1) begin
                map[rd_1] <= rn_1;
            end
        end
    end

    free_list free_list_i (
        .global_bus  (global_bus),
        .reset       (reset),
        .alloc_count (req_count),
        .alloc       (commit),
        .alloc_reg_0 (head_0),
        .alloc_reg_1 (head_1),
        .count       (free_count),
        .free_valid  (free_valid),
        .free_reg    (free_reg)
    );

endmodule

//--- hw/resolver/resolver.sv
/* takes a pair at most every second cycle, both slots must be valid.
   the driver holds an input pair until stop_out shows it was taken. */
`include "rename_defines.svh"

module resolver import rename_pkg::*, instr_pkg::*; (
    input  logic             global_bus,
    input  logic             reset,
    input  instr_name_e      dec_0_name,
    input  logic [`XLEN-1:0] dec_0_address,
    input  logic [`XLEN-1:0] dec_0_immediate,
    input  areg_t            dec_0_rs_1,
    input  areg_t            dec_0_rs_2,
    input  areg_t            dec_0_rd,
    input  instr_flags_t     dec_0_flags,
    input  st_type_e         dec_0_st_type,
    input  instr_name_e      dec_1_name,
    input  logic [`XLEN-1:0] dec_1_address,
    input  logic [`XLEN-1:0] dec_1_immediate,
    input  areg_t            dec_1_rs_1,
    input  areg_t            dec_1_rs_2,
    input  areg_t            dec_1_rd,
    input  instr_flags_t     dec_1_flags,
    input  st_type_e         dec_1_st_type,
    output instr_name_e      ren_0_name,
    output logic [`XLEN-1:0] ren_0_address,
    output logic [`XLEN-1:0] ren_0_immediate,
    output preg_t            ren_0_rs_1,
    output preg_t            ren_0_rs_2,
    output areg_t            ren_0_rd,
    output preg_t            ren_0_rn,
    output instr_flags_t     ren_0_flags,
    output st_type_e         ren_0_st_type,
    output instr_name_e      ren_1_name,
    output logic [`XLEN-1:0] ren_1_address,
    output logic [`XLEN-1:0] ren_1_immediate,
    output preg_t            ren_1_rs_1,
    output preg_t            ren_1_rs_2,
    output areg_t            ren_1_rd,
    output preg_t            ren_1_rn,
    output instr_flags_t     ren_1_flags,
    output st_type_e         ren_1_st_type,
    output areg_t            rs_1_0,
    output areg_t            rs_2_0,
    output areg_t            rd_0,
    output logic             rename_0,
    input  preg_t            src_1_0,
    input  preg_t            src_2_0,
    input  preg_t            rn_0,
    output areg_t            rs_1_1,
    output areg_t            rs_2_1,
    output areg_t            rd_1,
    output logic             rename_1,
    input  preg_t            src_1_1,
    input  preg_t            src_2_1,
    input  preg_t            rn_1,
    output logic             commit,
    input  logic             no_free,
    input  logic             stop_in,
    output logic             stop_out,
    input  logic             branch_resolved
);

    instr_types_e     pair_type;
    instr_name_e      p_0_name;
    instr_name_e      p_1_name;
    logic [`XLEN-1:0] p_0_address;
    logic [`XLEN-1:0] p_1_address;
    logic [`XLEN-1:0] p_0_immediate;
    logic [`XLEN-1:0] p_1_immediate;
    instr_flags_t     p_0_flags;
    instr_flags_t     p_1_flags;
    st_type_e         p_0_st_type;
    st_type_e         p_1_st_type;

    logic take;
    logic tag_active;
    logic tag_0;
    logic tag_1;
    logic slot_0_writes;
    logic fwd_1;
    logic fwd_2;

    assign take   = !stop_in && !stop_out && dec_0_name != UNKNOWN && dec_1_name != UNKNOWN;
    assign commit = stop_out && !no_free && !stop_in;

    // slot 1 reads what slot 0 writes in the same pair.
    assign slot_0_writes = rename_0 && rd_0 != '0;
    assign fwd_1         = slot_0_writes && rd_0 == rs_1_1;
    assign fwd_2         = slot_0_writes && rd_0 == rs_2_1;

    always_comb begin
        case (pair_type)
            NJ1NJ2: begin
                tag_0 = tag_active;
                tag_1 = tag_active;
            end
            NJ1J2: begin
                tag_0 = tag_active;
                tag_1 = 1'b0;
            end
            J1NJ2: begin
                tag_0 = 1'b0;
                tag_1 = 1'b1;
            end
            J1J2: begin
                tag_0 = 1'b0;
                tag_1 = 1'b0;
            end
            default: begin
                tag_0 = tag_active;
                tag_1 = tag_active;
            end
        endcase
    end

    always_ff @(posedge global_bus) begin
        if (take) begin
            case ({dec_0_flags.jumps, dec_1_flags.jumps})
                2'b00:   pair_type <= NJ1NJ2;
                2'b01:   pair_type <= NJ1J2;
                2'b10:   pair_type <= J1NJ2;
                2'b11:   pair_type <= J1J2;
                default: pair_type <= ERROR;
            endcase
            rs_1_0        <= dec_0_rs_1;
            rs_2_0        <= dec_0_rs_2;
            rd_0          <= dec_0_rd;
            rename_0      <= dec_0_flags.writes;
            rs_1_1        <= dec_1_rs_1;
            rs_2_1        <= dec_1_rs_2;
            rd_1          <= dec_1_rd;
            rename_1      <= dec_1_flags.writes;
            p_0_name      <= dec_0_name;
            p_0_address   <= dec_0_address;
            p_0_immediate <= dec_0_immediate;
            p_0_flags     <= dec_0_flags;
            p_0_st_type   <= dec_0_st_type;
            p_1_name      <= dec_1_name;
            p_1_address   <= dec_1_address;
            p_1_immediate <= dec_1_immediate;
            p_1_flags     <= dec_1_flags;
            p_1_st_type   <= dec_1_st_type;
        end
        if (commit) begin
            ren_0_address   <= p_0_address;
            ren_0_immediate <= p_0_immediate;
            ren_0_rs_1      <= src_1_0;
            ren_0_rs_2      <= src_2_0;
            ren_0_rd        <= rd_0;
            ren_0_rn        <= slot_0_writes ? rn_0 : '0;
            ren_0_flags     <= {p_0_flags.writes, p_0_flags.jumps, tag_0};
            ren_0_st_type   <= p_0_st_type;
            ren_1_address   <= p_1_address;
            ren_1_immediate <= p_1_immediate;
            ren_1_rs_1      <= fwd_1 ? rn_0 : src_1_1;
            ren_1_rs_2      <= fwd_2 ? rn_0 : src_2_1;
            ren_1_rd        <= rd_1;
            ren_1_rn        <= (rename_1 && rd_1 != '0) ? rn_1 : '0;
            ren_1_flags     <= {p_1_flags.writes, p_1_flags.jumps, tag_1};
            ren_1_st_type   <= p_1_st_type;
        end
    end

    always_ff @(posedge global_bus) begin
        if (reset) begin
            stop_out   <= 1'b0;
            tag_active <= 1'b0;
            ren_0_name <= UNKNOWN;
            ren_1_name <= UNKNOWN;
        end else begin
            if (take) begin
                stop_out <= 1'b1;
            end else if (commit) begin
                stop_out <= 1'b0;
            end
            // outputs hold while stop_in is high.
            if (commit) begin
                ren_0_name <= p_0_name;
                ren_1_name <= p_1_name;
            end else if (!stop_in) begin
                ren_0_name <= UNKNOWN;
                ren_1_name <= UNKNOWN;
            end
            // a new jump wins over a resolve in the same cycle.
            if (commit && pair_type inside {NJ1J2, J1NJ2, J1J2}) begin
                tag_active <= 1'b1;
            end else if (branch_resolved) begin
                tag_active <= 1'b0;
            end
        end
    end

endmodule

//--- hw/rename_top.sv
/* rename stage top, the resolver and the table joined port by port.
   free_valid releases one register per cycle, from commit. */
`include "rename_defines.svh"

module rename_top import rename_pkg::*, instr_pkg::*; (
    input  logic             global_bus,
    input  logic             reset,
    input  instr_name_e      dec_0_name,
    input  logic [`XLEN-1:0] dec_0_address,
    input  logic [`XLEN-1:0] dec_0_immediate,
    input  areg_t            dec_0_rs_1,
    input  areg_t            dec_0_rs_2,
    input  areg_t            dec_0_rd,
    input  instr_flags_t     dec_0_flags,
    input  st_type_e         dec_0_st_type,
    input  instr_name_e      dec_1_name,
    input  logic [`XLEN-1:0] dec_1_address,
    input  logic [`XLEN-1:0] dec_1_immediate,
    input  areg_t            dec_1_rs_1,
    input  areg_t            dec_1_rs_2,
    input  areg_t            dec_1_rd,
    input  instr_flags_t     dec_1_flags,
    input  st_type_e         dec_1_st_type,
    output instr_name_e      ren_0_name,
    output logic [`XLEN-1:0] ren_0_address,
    output logic [`XLEN-1:0] ren_0_immediate,
    output preg_t            ren_0_rs_1,
    output preg_t            ren_0_rs_2,
    output areg_t            ren_0_rd,
    output preg_t            ren_0_rn,
    output instr_flags_t     ren_0_flags,
    output st_type_e         ren_0_st_type,
    output instr_name_e      ren_1_name,
    output logic [`XLEN-1:0] ren_1_address,
    output logic [`XLEN-1:0] ren_1_immediate,
    output preg_t            ren_1_rs_1,
    output preg_t            ren_1_rs_2,
    output areg_t            ren_1_rd,
    output preg_t            ren_1_rn,
    output instr_flags_t     ren_1_flags,
    output st_type_e         ren_1_st_type,
    input  logic             stop_in,
    output logic             stop_out,
    input  logic             free_valid,
    input  preg_t            free_reg,
    input  logic             branch_resolved
);

    // query and answer between resolver and table.
    areg_t rs_1_0;
    areg_t rs_2_0;
    areg_t rd_0;
    logic  rename_0;
    preg_t src_1_0;
    preg_t src_2_0;
    preg_t rn_0;
    areg_t rs_1_1;
    areg_t rs_2_1;
    areg_t rd_1;
    logic  rename_1;
    preg_t src_1_1;
    preg_t src_2_1;
    preg_t rn_1;
    logic  commit;
    logic  no_free;

    resolver resolver_i (.*);

    rename_table rename_table_i (.*);

endmodule

//--- testbench/rename_tb.sv
/* directed tests of the rename stage against a map and free-list model.
   checks stop at the first mismatch; every wait gives up after 20 cycles. */
`include "rename_defines.svh"

module rename_tb import rename_pkg::*, instr_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    logic             global_bus;
    logic             reset;
    instr_name_e      dec_0_name, dec_1_name, ren_0_name, ren_1_name;
    logic [`XLEN-1:0] dec_0_address, dec_1_address, ren_0_address, ren_1_address;
    logic [`XLEN-1:0] dec_0_immediate, dec_1_immediate, ren_0_immediate, ren_1_immediate;
    areg_t            dec_0_rs_1, dec_0_rs_2, dec_0_rd, dec_1_rs_1, dec_1_rs_2, dec_1_rd;
    areg_t            ren_0_rd, ren_1_rd;
    preg_t            ren_0_rs_1, ren_0_rs_2, ren_0_rn, ren_1_rs_1, ren_1_rs_2, ren_1_rn;
    instr_flags_t     dec_0_flags, dec_1_flags, ren_0_flags, ren_1_flags;
    st_type_e         dec_0_st_type, dec_1_st_type, ren_0_st_type, ren_1_st_type;
    logic             stop_in;
    logic             stop_out;
    logic             free_valid;
    preg_t            free_reg;
    logic             branch_resolved;

    // reference model state.
    int          model_map [`ARCH_REGS];
    int          free_q [$];
    int          retired_q [$];
    logic        tag_active_m;
    logic [31:0] lfsr;
    logic [31:0] pc;
    instr_name_e sent_0_name;
    instr_name_e sent_1_name;

    rename_top rename_i (.*);

    always #5 global_bus = ~global_bus;

    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // random destination, never x0.
    function automatic areg_t rand_rd();
        areg_t r;
        r = areg_t'(next_bits(`AREG_W));
        if (r == '0) begin
            r = 1;
        end
        return r;
    endfunction

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch on %s", what);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("=== FAIL ===");
        $fatal(1, "timed out waiting for %s", what);
    endtask

    task automatic set_slot(input int slot, input instr_name_e name, input areg_t rs_1,
                            input areg_t rs_2, input areg_t rd, input logic writes,
                            input logic jumps);
        st_type_e st;
        st = (name == SW) ? ST_WORD : (name == SH) ? ST_HALF : (name == SB) ? ST_BYTE : ST_NONE;
        if (slot == 0) begin
            dec_0_name      = name;
            dec_0_address   = pc;
            dec_0_immediate = next_bits(32);
            dec_0_rs_1      = rs_1;
            dec_0_rs_2      = rs_2;
            dec_0_rd        = rd;
            dec_0_flags     = '{writes: writes, jumps: jumps, tag: 1'b0};
            dec_0_st_type   = st;
        end else begin
            dec_1_name      = name;
            dec_1_address   = pc;
            dec_1_immediate = next_bits(32);
            dec_1_rs_1      = rs_1;
            dec_1_rs_2      = rs_2;
            dec_1_rd        = rd;
            dec_1_flags     = '{writes: writes, jumps: jumps, tag: 1'b0};
            dec_1_st_type   = st;
        end
        pc = pc + 4;
    endtask

    // wait until the resolver takes the pair, then empty the input slots.
    task automatic send_pair();
        int n;
        n           = 0;
        sent_0_name = dec_0_name;
        sent_1_name = dec_1_name;
        @(posedge global_bus);
        #1;
        while (!stop_out) begin
            if (n == 20) begin
                timeout_fail("pair acceptance");
            end
            @(posedge global_bus);
            #1;
            n++;
        end
        dec_0_name = UNKNOWN;
        dec_1_name = UNKNOWN;
    endtask

    task automatic expect_pair();
        int   rn_0;
        int   rn_1;
        int   s_1_0;
        int   s_2_0;
        int   s_1_1;
        int   s_2_1;
        int   n;
        logic req_0;
        logic req_1;
        logic t_0;
        logic t_1;
        req_0 = dec_0_flags.writes && dec_0_rd != 0;
        req_1 = dec_1_flags.writes && dec_1_rd != 0;
        rn_0  = req_0 ? free_q.pop_front() : 0;
        rn_1  = req_1 ? free_q.pop_front() : 0;
        s_1_0 = model_map[dec_0_rs_1];
        s_2_0 = model_map[dec_0_rs_2];
        s_1_1 = (req_0 && dec_0_rd == dec_1_rs_1) ? rn_0 : model_map[dec_1_rs_1];
        s_2_1 = (req_0 && dec_0_rd == dec_1_rs_2) ? rn_0 : model_map[dec_1_rs_2];
        // a jump is tag 0, the slot behind it tag 1.
        t_0 = dec_0_flags.jumps ? 1'b0 : tag_active_m;
        t_1 = dec_1_flags.jumps ? 1'b0 : (dec_0_flags.jumps ? 1'b1 : tag_active_m);
        if (req_0) begin
            retired_q.push_back(model_map[dec_0_rd]);
            model_map[dec_0_rd] = rn_0;
        end
        if (req_1) begin
            retired_q.push_back(model_map[dec_1_rd]);
            model_map[dec_1_rd] = rn_1;
        end
        if (dec_0_flags.jumps || dec_1_flags.jumps) begin
            tag_active_m = 1'b1;
        end
        n = 0;
        while (ren_0_name == UNKNOWN) begin
            if (n == 20) begin
                timeout_fail("renamed pair");
            end
            @(posedge global_bus);
            #1;
            n++;
        end
        compare("slot 0 name", ren_0_name, sent_0_name);
        compare("slot 0 address", ren_0_address, dec_0_address);
        compare("slot 0 immediate", ren_0_immediate, dec_0_immediate);
        compare("slot 0 rs_1", ren_0_rs_1, s_1_0);
        compare("slot 0 rs_2", ren_0_rs_2, s_2_0);
        compare("slot 0 rd", ren_0_rd, dec_0_rd);
        compare("slot 0 rn", ren_0_rn, rn_0);
        compare("slot 0 flags", ren_0_flags, {dec_0_flags.writes, dec_0_flags.jumps, t_0});
        compare("slot 0 st_type", ren_0_st_type, dec_0_st_type);
        compare("slot 1 name", ren_1_name, sent_1_name);
        compare("slot 1 address", ren_1_address, dec_1_address);
        compare("slot 1 immediate", ren_1_immediate, dec_1_immediate);
        compare("slot 1 rs_1", ren_1_rs_1, s_1_1);
        compare("slot 1 rs_2", ren_1_rs_2, s_2_1);
        compare("slot 1 rd", ren_1_rd, dec_1_rd);
        compare("slot 1 rn", ren_1_rn, rn_1);
        compare("slot 1 flags", ren_1_flags, {dec_1_flags.writes, dec_1_flags.jumps, t_1});
        compare("slot 1 st_type", ren_1_st_type, dec_1_st_type);
    endtask

    task automatic run_pair();
        send_pair();
        expect_pair();
    endtask

    task automatic random_writing_pair();
        set_slot(0, ADD, areg_t'(next_bits(5)), areg_t'(next_bits(5)), rand_rd(), 1'b1, 1'b0);
        set_slot(1, SUB, areg_t'(next_bits(5)), areg_t'(next_bits(5)), rand_rd(), 1'b1, 1'b0);
        run_pair();
    endtask

    // hands retired registers back, one per cycle.
    task automatic release_regs(input int count);
        int r;
        for (int i = 0; i < count; i++) begin
            r          = retired_q.pop_front();
            free_valid = 1'b1;
            free_reg   = preg_t'(r);
            free_q.push_back(r);
            @(posedge global_bus);
            #1;
        end
        free_valid = 1'b0;
    endtask

    task automatic identity_after_reset();
        set_slot(0, SW, 5'd3, 5'd4, 5'd0, 1'b0, 1'b0);
        set_slot(1, SB, 5'd5, 5'd6, 5'd0, 1'b0, 1'b0);
        run_pair();
        compare("identity rs_1", ren_0_rs_1, 3);
        compare("identity rs_2", ren_1_rs_2, 6);
    endtask

    task automatic allocation_order();
        areg_t last_0;
        areg_t last_1;
        random_writing_pair();
        compare("first allocation", ren_0_rn, 32);
        compare("second allocation", ren_1_rn, 33);
        random_writing_pair();
        random_writing_pair();
        last_0 = dec_0_rd;
        last_1 = dec_1_rd;
        // read back the destinations just renamed.
        set_slot(0, ADD, last_0, last_1, rand_rd(), 1'b1, 1'b0);
        set_slot(1, XOR, last_1, last_0, rand_rd(), 1'b1, 1'b0);
        run_pair();
    endtask

    task automatic pair_bypass();
        areg_t r;
        r = rand_rd();
        set_slot(0, ADDI, 5'd7, 5'd0, r, 1'b1, 1'b0);
        set_slot(1, ADD, r, r, 5'd0, 1'b1, 1'b0);
        run_pair();
        compare("bypass rs_1", ren_1_rs_1, model_map[r]);
        compare("bypass rs_2", ren_1_rs_2, model_map[r]);
        compare("x0 rn", ren_1_rn, 0);
    endtask

    task automatic free_list_stall();
        while (free_q.size() >= 2) begin
            random_writing_pair();
        end
        set_slot(0, OR, areg_t'(next_bits(5)), areg_t'(next_bits(5)), rand_rd(), 1'b1, 1'b0);
        set_slot(1, AND, areg_t'(next_bits(5)), areg_t'(next_bits(5)), rand_rd(), 1'b1, 1'b0);
        send_pair();
        repeat (4) begin
            @(posedge global_bus);
            #1;
            compare("stop_out while stalled", stop_out, 1);
            compare("name while stalled", ren_0_name, UNKNOWN);
        end
        release_regs(2);
        expect_pair();
        // room for the tests that follow.
        release_regs(10);
    endtask

    // outputs of the last pair hold while stop_in is high.
    task automatic stop_in_block();
        random_writing_pair();
        stop_in = 1'b1;
        set_slot(0, SLT, areg_t'(next_bits(5)), areg_t'(next_bits(5)), rand_rd(), 1'b1, 1'b0);
        set_slot(1, SLTU, areg_t'(next_bits(5)), areg_t'(next_bits(5)), rand_rd(), 1'b1, 1'b0);
        repeat (4) begin
            @(posedge global_bus);
            #1;
            compare("stop_out under stop_in", stop_out, 0);
            compare("slot 0 name under stop_in", ren_0_name, sent_0_name);
            compare("slot 1 name under stop_in", ren_1_name, sent_1_name);
        end
        stop_in = 1'b0;
        run_pair();
    endtask

    task automatic jump_tags();
        set_slot(0, JAL, 5'd0, 5'd0, rand_rd(), 1'b1, 1'b1);
        set_slot(1, ADD, areg_t'(next_bits(5)), areg_t'(next_bits(5)), rand_rd(), 1'b1, 1'b0);
        run_pair();
        compare("jump tag", ren_0_flags.tag, 0);
        compare("tag behind jump", ren_1_flags.tag, 1);
        random_writing_pair();
        compare("tag while unresolved", ren_0_flags.tag, 1);
        branch_resolved = 1'b1;
        tag_active_m    = 1'b0;
        @(posedge global_bus);
        #1;
        branch_resolved = 1'b0;
        random_writing_pair();
        compare("tag after resolve", ren_1_flags.tag, 0);
    endtask

    initial begin
        global_bus      = 1'b0;
        reset           = 1'b1;
        dec_0_name      = UNKNOWN;
        dec_1_name      = UNKNOWN;
        dec_0_address   = '0;
        dec_1_address   = '0;
        dec_0_immediate = '0;
        dec_1_immediate = '0;
        dec_0_rs_1      = '0;
        dec_0_rs_2      = '0;
        dec_0_rd        = '0;
        dec_1_rs_1      = '0;
        dec_1_rs_2      = '0;
        dec_1_rd        = '0;
        dec_0_flags     = '0;
        dec_1_flags     = '0;
        dec_0_st_type   = ST_NONE;
        dec_1_st_type   = ST_NONE;
        stop_in         = 1'b0;
        free_valid      = 1'b0;
        free_reg        = '0;
        branch_resolved = 1'b0;
        lfsr            = 32'h399aa706;
        pc              = 32'h1000;
        tag_active_m    = 1'b0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            model_map[i] = i;
        end
        for (int i = `ARCH_REGS; i < `PHYS_REGS; i++) begin
            free_q.push_back(i);
        end
        repeat (5) @(posedge global_bus);
        #1;
        reset = 1'b0;
        identity_after_reset();
        allocation_order();
        pair_bypass();
        free_list_stall();
        stop_in_block();
        jump_tags();
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- tb.f
+incdir+common
common/instr_pkg.sv
common/rename_pkg.sv
hw/rename_table/free_list.sv
hw/rename_table/rename_table.sv
hw/resolver/resolver.sv
hw/rename_top.sv
testbench/rename_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the rename stage testbench with Verilator and runs it.
# the exit status is the simulator's, so a failed check fails the script.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal \
        --top-module rename_tb -f tb.f; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vrename_tb; then
    echo "simulation reported a failure"
    exit 1
fi

exit 0
